// File: bench/st_bus_glue_assertions.sv
// st bus glue assertions: sdram read/write exclusion, upload pulse width, sticky viking flag
`timescale 1ns/1ps

module st_bus_glue_assertions (
	input logic clk_32,
	input logic xsint,
	input logic sdram_oe_i,
	input logic sdram_we_i,
	input logic upload_wr_i,      // internal pulse of the top level
	input logic viking_active_i
);

	// one slot is either a read or a write
	oe_we_exclusive: assert property (@(posedge clk_32) disable iff (!xsint)
		!(sdram_oe_i && sdram_we_i))
		else $error("sdram oe and we high in the same cycle");

	// one write per toggled strobe
	upload_single_cycle: assert property (@(posedge clk_32) disable iff (!xsint)
		upload_wr_i |=> !upload_wr_i)
		else $error("upload write pulse longer than one cycle");

	// driver seen once, stays seen
	viking_sticky: assert property (@(posedge clk_32) disable iff (!xsint)
		viking_active_i |=> viking_active_i)
		else $error("viking active dropped outside reset");

endmodule

// attached to every st_bus_glue instance
bind st_bus_glue st_bus_glue_assertions u_assert (
	.clk_32          (clk_32),
	.xsint           (xsint),
	.sdram_oe_i      (sdram_oe_o),
	.sdram_we_i      (sdram_we_o),
	.upload_wr_i     (upload_wr),
	.viking_active_i (viking_active_o)
);

// File: bench/st_bus_glue_tb.sv
// st bus glue testbench: table of bus scenarios run against the memory glue top level
`timescale 1ns/1ps

module st_bus_glue_tb;
	import st_glue_pkg::*;

	localparam int CLK_PERIOD      = 10;
	localparam int RESET_CYCLES    = 5;
	localparam int DRIVE_DLY       = 1;    // ns after the rising edge
	localparam int NUM_ROWS        = 21;
	localparam int ROW_CYCLES      = 300;  // worst row, 256 viking hits plus setup
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_ROWS * ROW_CYCLES + 100;

	// row kinds
	localparam int K_RESET    = 0;
	localparam int K_WIN_IN   = 1;
	localparam int K_WIN_OUT  = 2;
	localparam int K_UPLOAD   = 3;
	localparam int K_BLIT_RD  = 4;
	localparam int K_BLIT_WR  = 5;
	localparam int K_TOS      = 6;
	localparam int K_VIK_HITS = 7;
	localparam int K_VIK_READ = 8;

	logic       clk_32;
	logic       xsint;
	sys_ctrl_t  sys_ctrl;
	bus_cycle_e bus_cycle;
	logic       mhz8_en1, as_n, rom2_n;
	word_addr_t cpu_addr, mcu_addr, dio_addr, blitter_addr, viking_addr;
	logic       mcu_ras_n, mcu_we_n, mcu_uds, mcu_lds;
	bus_word_t  mcu_data, dio_data, blitter_data;
	logic       dio_download, dio_strobe;
	logic       blitter_bgack, blitter_read, blitter_write, viking_read;
	word_addr_t sdram_addr, rom_addr;
	bus_word_t  sdram_data;
	logic       sdram_oe, sdram_we, sdram_uds, sdram_lds;
	logic       tos192k, viking_active;

	string       row_name [NUM_ROWS];
	int          row_kind [NUM_ROWS];
	int          row_arg  [NUM_ROWS];
	logic [31:0] row_exp  [NUM_ROWS];
	int          row_cnt;
	int          errors;
	logic [31:0] lfsr_state;

	st_bus_glue UUT (
		.clk_32 (clk_32), .xsint (xsint), .sys_ctrl_i (sys_ctrl),
		.bus_cycle_i (bus_cycle), .mhz8_en1_i (mhz8_en1), .as_n_i (as_n),
		.cpu_addr_i (cpu_addr), .mcu_addr_i (mcu_addr), .mcu_ras_n_i (mcu_ras_n),
		.mcu_we_n_i (mcu_we_n), .mcu_uds_i (mcu_uds), .mcu_lds_i (mcu_lds),
		.mcu_data_i (mcu_data), .rom2_n_i (rom2_n), .dio_download_i (dio_download),
		.dio_addr_i (dio_addr), .dio_data_i (dio_data), .dio_strobe_i (dio_strobe),
		.blitter_bgack_i (blitter_bgack), .blitter_addr_i (blitter_addr),
		.blitter_read_i (blitter_read), .blitter_write_i (blitter_write),
		.blitter_data_i (blitter_data), .viking_read_i (viking_read),
		.viking_addr_i (viking_addr), .sdram_addr_o (sdram_addr),
		.sdram_data_o (sdram_data), .sdram_oe_o (sdram_oe), .sdram_we_o (sdram_we),
		.sdram_uds_o (sdram_uds), .sdram_lds_o (sdram_lds), .rom_addr_o (rom_addr),
		.tos192k_o (tos192k), .viking_active_o (viking_active)
	);

	initial begin
		clk_32 = 1'b0;
		forever #(CLK_PERIOD / 2) clk_32 = ~clk_32;
	end

	// fibonacci lfsr, taps 32 22 2 1, one step per bit taken
	task automatic draw_bits(input int n, output logic [31:0] v);
		logic fb;
		v = '0;
		repeat (n) begin
			fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
			lfsr_state = {lfsr_state[30:0], fb};
			v          = {v[30:0], fb};
		end
	endtask

	task automatic check(input string what, input logic [31:0] exp_v, input logic [31:0] act_v);
		if (exp_v !== act_v) begin
			errors++;
			$display("FAILED %s: expected %h, actual %h", what, exp_v, act_v);
		end
	endtask

	// byte size of st ram per size code
	function automatic int mem_limit(input int code);
		case (mem_size_e'(code))
			MEM_512K: return 'h080000;
			MEM_1M:   return 'h100000;
			MEM_2M:   return 'h200000;
			MEM_4M:   return 'h400000;
			MEM_8M:   return 'h800000;
			MEM_14M:  return 'he00000;  // rom area starts here
			default:  return 0;
		endcase
	endfunction

	task automatic next_cycle();
		@(posedge clk_32);
		#DRIVE_DLY;
	endtask

	// everything quiet, strobe and ctrl word left alone
	task automatic set_idle();
		bus_cycle     = CYC_SPARE;
		mhz8_en1      = 1'b0;
		as_n          = 1'b1;
		cpu_addr      = '0;
		mcu_addr      = '0;
		mcu_ras_n     = 1'b1;
		mcu_we_n      = 1'b1;
		mcu_uds       = 1'b0;
		mcu_lds       = 1'b0;
		mcu_data      = '0;
		rom2_n        = 1'b1;
		dio_download  = 1'b0;
		dio_addr      = '0;
		dio_data      = '0;
		blitter_bgack = 1'b0;
		blitter_addr  = '0;
		blitter_read  = 1'b0;
		blitter_write = 1'b0;
		blitter_data  = '0;
		viking_read   = 1'b0;
		viking_addr   = '0;
	endtask

	task automatic add_row(input string nm, input int kind, input int arg, input logic [31:0] e);
		row_name[row_cnt] = nm;
		row_kind[row_cnt] = kind;
		row_arg[row_cnt]  = arg;
		row_exp[row_cnt]  = e;
		row_cnt++;
	endtask

	task automatic build_table();
		int c;
		row_cnt = 0;
		add_row("reset_state", K_RESET, 0, 32'h0);  // {we, oe, viking, tos}
		for (c = 0; c < 6; c++) begin
			add_row($sformatf("window_in_%0d", c), K_WIN_IN, c, 32'h1);
			add_row($sformatf("window_out_%0d", c), K_WIN_OUT, c, 32'h0);
		end
		add_row("upload_word", K_UPLOAD, 'h010000, 32'h1);
		add_row("blitter_read", K_BLIT_RD, 0, 32'h2);   // {oe, we}
		add_row("blitter_write", K_BLIT_WR, 0, 32'h1);
		add_row("tos_192k", K_TOS, 'hfc0000, 32'h01fc_0000);  // bit 24 flag, rest bank
		add_row("tos_256k", K_TOS, 'he00000, 32'h00e0_0000);
		add_row("viking_255_hits", K_VIK_HITS, 255, 32'h0);
		add_row("viking_256th_hit", K_VIK_HITS, 1, 32'h1);
		add_row("viking_read", K_VIK_READ, 0, 32'h1);
	endtask

	// strobe change in a pre-cycle, write slot in the following cpu cycle
	task automatic upload_word(input string nm, input logic [23:0] baddr,
		input logic [15:0] data, input logic exp_we);
		dio_download = 1'b1;
		dio_addr     = baddr[23:1];
		dio_data     = data;
		bus_cycle    = CYC_PRE;
		mhz8_en1     = 1'b1;
		dio_strobe   = ~dio_strobe;  // next word
		@(negedge clk_32);
		check({nm, " we before sample"}, 32'h0, 32'(sdram_we));
		next_cycle();
		bus_cycle = CYC_CPU;
		mhz8_en1  = 1'b0;
		@(negedge clk_32);
		check({nm, " we"}, 32'(exp_we), 32'(sdram_we));
		check({nm, " oe"}, 32'h0, 32'(sdram_oe));
		check({nm, " addr"}, 32'(baddr[23:1]), 32'(sdram_addr));
		check({nm, " data"}, 32'(data), 32'(sdram_data));
		check({nm, " byte strobes"}, 32'h3, 32'({sdram_uds, sdram_lds}));
		next_cycle();
		@(negedge clk_32);
		check({nm, " we after pulse"}, 32'h0, 32'(sdram_we));  // one cycle only
		next_cycle();
		set_idle();
	endtask

	task automatic apply_row(input int i);
		string       nm;
		logic [31:0] r;
		logic [23:0] baddr;
		logic [23:0] rb;
		logic [15:0] data_w;
		int          lim;
		int          n;
		nm = row_name[i];
		next_cycle();
		set_idle();
		sys_ctrl = '0;
		case (row_kind[i])
			K_RESET: begin
				@(negedge clk_32);
				check(nm, row_exp[i], 32'({sdram_we, sdram_oe, viking_active, tos192k}));
			end
			K_WIN_IN, K_WIN_OUT: begin
				lim = mem_limit(row_arg[i]);
				draw_bits(24, r);
				if (row_kind[i] == K_WIN_IN)
					baddr = 24'((int'(r) % lim) | 2);  // never word 0
				else
					baddr = 24'(lim);                  // first byte past ram top
				sys_ctrl[3:1] = 3'(row_arg[i]);
				bus_cycle     = CYC_CPU;
				mcu_addr      = baddr[23:1];
				next_cycle();
				mcu_ras_n = 1'b0;  // ras falls, mmu read
				@(negedge clk_32);
				check({nm, " oe"}, row_exp[i], 32'(sdram_oe));
				check({nm, " addr"}, 32'(baddr[23:1]), 32'(sdram_addr));
			end
			K_UPLOAD: begin
				draw_bits(16, r);
				baddr = 24'(row_arg[i]) | {8'h00, r[15:1], 1'b0};
				draw_bits(16, r);
				upload_word(nm, baddr, r[15:0], row_exp[i][0]);
			end
			K_BLIT_RD, K_BLIT_WR: begin
				draw_bits(24, r);
				bus_cycle = CYC_CPU;
				mcu_addr  = r[23:1];
				mcu_we_n  = 1'b0;  // mmu wants a write in the same slot
				next_cycle();
				mcu_ras_n     = 1'b0;
				blitter_bgack = 1'b1;
				draw_bits(24, r);
				blitter_addr  = r[23:1];
				draw_bits(16, r);
				blitter_data  = r[15:0];
				blitter_read  = (row_kind[i] == K_BLIT_RD);
				blitter_write = (row_kind[i] == K_BLIT_WR);
				@(negedge clk_32);
				check({nm, " oe/we"}, row_exp[i], 32'({sdram_oe, sdram_we}));
				check({nm, " addr"}, 32'(blitter_addr), 32'(sdram_addr));
				check({nm, " data"}, 32'(blitter_data), 32'(sdram_data));
			end
			K_TOS: begin
				draw_bits(16, r);
				baddr = 24'(row_arg[i]) | {8'h00, r[15:1], 1'b0};
				draw_bits(16, r);
				data_w = r[15:0];
				upload_word(nm, baddr, data_w, 1'b1);
				draw_bits(24, r);
				rom2_n   = 1'b0;
				cpu_addr = r[23:1];
				rb       = row_exp[i][23:0] | (r[23:0] & 24'h03fffe);  // 128k words into bank
				@(negedge clk_32);
				check({nm, " tos192k"}, 32'(row_exp[i][24]), 32'(tos192k));
				check({nm, " rom addr"}, 32'(rb[23:1]), 32'(rom_addr));
			end
			K_VIK_HITS: begin
				sys_ctrl[28]  = 1'b1;  // viking card fitted
				sys_ctrl[3:1] = 3'd3;  // 4 MB
				bus_cycle     = CYC_CPU;
				for (n = 0; n < row_arg[i]; n++) begin
					next_cycle();
					draw_bits(18, r);
					cpu_addr = {6'b110000, r[17:1]};  // $c00000 window
					mhz8_en1 = 1'b1;
					as_n     = 1'b0;
				end
				next_cycle();
				mhz8_en1 = 1'b0;
				as_n     = 1'b1;
				@(negedge clk_32);
				check({nm, " viking active"}, row_exp[i], 32'(viking_active));
			end
			K_VIK_READ: begin
				sys_ctrl[28]  = 1'b1;
				sys_ctrl[3:1] = 3'd3;
				draw_bits(18, r);
				bus_cycle     = CYC_VIDEO;
				viking_read   = 1'b1;
				viking_addr   = {6'b110000, r[17:1]};
				@(negedge clk_32);
				check({nm, " oe"}, row_exp[i], 32'(sdram_oe));
				check({nm, " addr"}, 32'(viking_addr), 32'(sdram_addr));
			end
			default: begin
				errors++;
				$display("row %0d has an unknown kind %0d", i, row_kind[i]);
			end
		endcase
	endtask

	initial begin
		int i;
		int err_before;
		int tests_bad;
		errors     = 0;
		tests_bad  = 0;
		lfsr_state = 32'hd24e_a3c0;
		xsint      = 1'b0;
		dio_strobe = 1'b0;
		sys_ctrl   = '0;
		set_idle();
		build_table();
		repeat (RESET_CYCLES) @(posedge clk_32);
		#DRIVE_DLY;
		xsint = 1'b1;
		for (i = 0; i < row_cnt; i++) begin
			err_before = errors;
			apply_row(i);
			if (errors == err_before) begin
				$display("test %0d %s: ok", i, row_name[i]);
			end else begin
				tests_bad++;
				$display("test %0d %s: mismatch", i, row_name[i]);
			end
		end
		$display("%0d tests, %0d ok, %0d with mismatches, %0d check errors",
			row_cnt, row_cnt - tests_bad, tests_bad, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// whole table plus margin, then give up
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_32);
		$display("watchdog expired after %0d cycles, test table did not finish", WATCHDOG_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: common/st_glue_params.svh
// st glue parameters: bus widths, viking and tos window tags, rom bank codes
`ifndef ST_GLUE_PARAMS_SVH
`define ST_GLUE_PARAMS_SVH

// word address runs from bit 23 down to bit 1
`define ST_ADDR_W 23

// 16 bit st data bus
`define ST_DATA_W 16

// control word as delivered by the io controller
`define ST_CTRL_W 32

// viking driver detection, counter saturates at all ones
`define ST_VIKING_COUNT_W 8

// top six address bits of the viking frame buffer
`define ST_VIKING_LO_TAG 6'b110000   // $c00000, normal st/ste
`define ST_VIKING_HI_TAG 6'b111010   // $e80000, steroids mode

// upload tags, compared against the upper bits of the upload address
`define ST_TOS192_TAG 6'b111111      // $fc0000, 192k tos image
`define ST_TOS256_TAG 4'he           // $e00000, 256k tos image

// upper six bits of a remapped rom2 address
`define ST_ROM_BANK_256 6'b111000    // e0 bank
`define ST_ROM_BANK_192 6'b111111    // fc bank

`endif

// File: common/st_glue_pkg.sv
// st glue package: shared bus, control and request types of the memory glue
`include "st_glue_params.svh"

package st_glue_pkg;

	// cpu/chipset word address, bit 0 never exists on the 68000 bus
	typedef logic [`ST_ADDR_W:1] word_addr_t;

	// one data bus word
	typedef logic [`ST_DATA_W-1:0] bus_word_t;

	// system control word from the io controller
	typedef logic [`ST_CTRL_W-1:0] sys_ctrl_t;

	// ram size codes, ctrl bits 3..1
	typedef enum logic [2:0] {
		MEM_512K = 3'd0,
		MEM_1M   = 3'd1,
		MEM_2M   = 3'd2,
		MEM_4M   = 3'd3,
		MEM_8M   = 3'd4,
		MEM_14M  = 3'd5
	} mem_size_e;

	// four phase bus cycle from the mmu
	typedef enum logic [1:0] {
		CYC_PRE   = 2'd0,  // cpu pre-cycle, upload strobe sampled here
		CYC_CPU   = 2'd1,  // cpu / blitter / upload slot
		CYC_VIDEO = 2'd2,  // shifter and viking slot
		CYC_SPARE = 2'd3
	} bus_cycle_e;

	// who owns the sdram request this cycle
	typedef enum logic [1:0] {
		SRC_MCU     = 2'd0,
		SRC_UPLOAD  = 2'd1,
		SRC_BLITTER = 2'd2,
		SRC_VIKING  = 2'd3
	} ram_src_e;

endpackage

// File: logic/st_bus_glue.sv
// st bus glue top: config decode, viking detect, tos upload and sdram request select
`timescale 1ns/1ps

module st_bus_glue (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  st_glue_pkg::sys_ctrl_t  sys_ctrl_i,
	input  st_glue_pkg::bus_cycle_e bus_cycle_i,
	input  logic                    mhz8_en1_i,
	input  logic                    as_n_i,
	input  st_glue_pkg::word_addr_t cpu_addr_i,
	input  st_glue_pkg::word_addr_t mcu_addr_i,
	input  logic                    mcu_ras_n_i,
	input  logic                    mcu_we_n_i,
	input  logic                    mcu_uds_i,
	input  logic                    mcu_lds_i,
	input  st_glue_pkg::bus_word_t  mcu_data_i,
	input  logic                    rom2_n_i,
	input  logic                    dio_download_i,
	input  st_glue_pkg::word_addr_t dio_addr_i,
	input  st_glue_pkg::bus_word_t  dio_data_i,
	input  logic                    dio_strobe_i,
	input  logic                    blitter_bgack_i,
	input  st_glue_pkg::word_addr_t blitter_addr_i,
	input  logic                    blitter_read_i,
	input  logic                    blitter_write_i,
	input  st_glue_pkg::bus_word_t  blitter_data_i,
	input  logic                    viking_read_i,
	input  st_glue_pkg::word_addr_t viking_addr_i,
	output st_glue_pkg::word_addr_t sdram_addr_o,
	output st_glue_pkg::bus_word_t  sdram_data_o,
	output logic                    sdram_oe_o,
	output logic                    sdram_we_o,
	output logic                    sdram_uds_o,
	output logic                    sdram_lds_o,
	output st_glue_pkg::word_addr_t rom_addr_o,
	output logic                    tos192k_o,        // back to the mmu
	output logic                    viking_active_o
);
	import st_glue_pkg::*;

	logic      steroids;
	logic      viking_enable;
	mem_size_e mem_size;
	logic      upload_wr;     // one clock per uploaded word

	// ste and mega ste flags only matter to the dropped chipset parts
	sys_config_decode u_cfg (
		.sys_ctrl_i      (sys_ctrl_i),
		.ste_o           (),
		.mste_o          (),
		.steroids_o      (steroids),
		.mem_size_o      (mem_size),
		.viking_enable_o (viking_enable)
	);

	viking_detect u_vdet (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.mhz8_en1_i      (mhz8_en1_i),
		.as_n_i          (as_n_i),
		.cpu_addr_i      (cpu_addr_i),
		.viking_enable_i (viking_enable),
		.steroids_i      (steroids),
		.viking_active_o (viking_active_o)
	);

	tos_upload_ctrl u_tos (
		.clk_32         (clk_32),
		.xsint          (xsint),
		.bus_cycle_i    (bus_cycle_i),
		.mhz8_en1_i     (mhz8_en1_i),
		.dio_strobe_i   (dio_strobe_i),
		.dio_download_i (dio_download_i),
		.dio_addr_i     (dio_addr_i),
		.rom2_n_i       (rom2_n_i),
		.cpu_addr_i     (cpu_addr_i),
		.upload_wr_o    (upload_wr),
		.tos192k_o      (tos192k_o),
		.rom_addr_o     (rom_addr_o)
	);

	ram_request_select u_sel (
		.clk_32          (clk_32),
		.xsint           (xsint),
		.bus_cycle_i     (bus_cycle_i),
		.mem_size_i      (mem_size),
		.viking_enable_i (viking_enable),
		.steroids_i      (steroids),
		.viking_active_i (viking_active_o),
		.mcu_addr_i      (mcu_addr_i),
		.mcu_ras_n_i     (mcu_ras_n_i),
		.mcu_we_n_i      (mcu_we_n_i),
		.mcu_uds_i       (mcu_uds_i),
		.mcu_lds_i       (mcu_lds_i),
		.mcu_data_i      (mcu_data_i),
		.dio_download_i  (dio_download_i),
		.upload_wr_i     (upload_wr),
		.dio_addr_i      (dio_addr_i),
		.dio_data_i      (dio_data_i),
		.blitter_bgack_i (blitter_bgack_i),
		.blitter_read_i  (blitter_read_i),
		.blitter_write_i (blitter_write_i),
		.blitter_addr_i  (blitter_addr_i),
		.blitter_data_i  (blitter_data_i),
		.viking_read_i   (viking_read_i),
		.viking_addr_i   (viking_addr_i),
		.sdram_addr_o    (sdram_addr_o),
		.sdram_data_o    (sdram_data_o),
		.sdram_oe_o      (sdram_oe_o),
		.sdram_we_o      (sdram_we_o),
		.sdram_uds_o     (sdram_uds_o),
		.sdram_lds_o     (sdram_lds_o)
	);

endmodule

// File: logic/sys_config_decode.sv
// system config decoder: machine flavour, ram size and viking enable from the ctrl word
`timescale 1ns/1ps

module sys_config_decode (
	input  st_glue_pkg::sys_ctrl_t sys_ctrl_i,
	output logic                   ste_o,
	output logic                   mste_o,
	output logic                   steroids_o,
	output st_glue_pkg::mem_size_e mem_size_o,
	output logic                   viking_enable_o
);
	import st_glue_pkg::*;

	// control word bit positions
	localparam int STE_BIT    = 23;
	localparam int MSTE_BIT   = 24;
	localparam int VIKING_BIT = 28;
	localparam int MEM_LSB    = 1;  // size code in bits 3..1

	logic ste_bit;
	logic mste_bit;
	logic viking_bit;
	logic viking_mem_ok;  // viking fits below the ram top

	assign ste_bit    = sys_ctrl_i[STE_BIT];
	assign mste_bit   = sys_ctrl_i[MSTE_BIT];
	assign viking_bit = sys_ctrl_i[VIKING_BIT];

	// either flavour bit gives ste features
	assign ste_o  = ste_bit | mste_bit;
	assign mste_o = mste_bit;

	// both bits set: ste on steroids
	assign steroids_o = ste_bit & mste_bit;

	// raw size code, codes 6 and 7 unused
	assign mem_size_o = mem_size_e'(sys_ctrl_i[MEM_LSB +: 3]);

	// frame buffer at $c00000 collides with ram above 8 MB
	always_comb begin
		case (mem_size_o)
			MEM_512K,
			MEM_1M,
			MEM_2M,
			MEM_4M,
			MEM_8M:  viking_mem_ok = 1'b1;
			default: viking_mem_ok = 1'b0;  // 14M and undefined codes
		endcase
	end

	// steroids moves the card to $e80000, so any size is fine there
	assign viking_enable_o = (viking_bit & viking_mem_ok) | steroids_o;

endmodule

// File: logic/tos_upload_ctrl.sv
// tos upload control: upload write pulse, 192k tos flag and rom2 address remap
`timescale 1ns/1ps
`include "st_glue_params.svh"

module tos_upload_ctrl (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  st_glue_pkg::bus_cycle_e bus_cycle_i,
	input  logic                    mhz8_en1_i,
	input  logic                    dio_strobe_i,    // toggles once per word
	input  logic                    dio_download_i,
	input  st_glue_pkg::word_addr_t dio_addr_i,
	input  logic                    rom2_n_i,
	input  st_glue_pkg::word_addr_t cpu_addr_i,
	output logic                    upload_wr_o,
	output logic                    tos192k_o,
	output st_glue_pkg::word_addr_t rom_addr_o
);
	import st_glue_pkg::*;

	localparam logic [5:0] TOS192_TAG = `ST_TOS192_TAG;
	localparam logic [3:0] TOS256_TAG = `ST_TOS256_TAG;
	localparam logic [5:0] BANK_256   = `ST_ROM_BANK_256;
	localparam logic [5:0] BANK_192   = `ST_ROM_BANK_192;

	logic       strobe_q;     // strobe level seen at the last sample
	logic       sample_en;    // pre-cycle slot on the 8 MHz enable
	logic       strobe_chg;
	logic       tag_192;      // upload lands in $fc0000 and up
	logic       tag_256;      // upload lands in $e00000 area
	logic [5:0] rom_bank;

	assign sample_en  = (bus_cycle_i == CYC_PRE) & mhz8_en1_i;
	assign strobe_chg = dio_strobe_i ^ strobe_q;

	assign tag_192 = (dio_addr_i[23:18] == TOS192_TAG);
	assign tag_256 = (dio_addr_i[23:20] == TOS256_TAG);

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			strobe_q    <= 1'b0;
			upload_wr_o <= 1'b0;
			tos192k_o   <= 1'b0;
		end else begin
			upload_wr_o <= 1'b0;  // single cycle pulse
			if (sample_en) begin
				strobe_q <= dio_strobe_i;
				if (strobe_chg)
					upload_wr_o <= 1'b1;  // lands in the following cpu slot
			end

			// image size follows the load address of the upload
			if (dio_download_i) begin
				if (tag_192)
					tos192k_o <= 1'b1;
				else if (tag_256)
					tos192k_o <= 1'b0;
			end
		end
	end

	// 192k tos lives at $fc0000, 256k tos at $e00000
	assign rom_bank = tos192k_o ? BANK_192 : BANK_256;

	// only rom2 is remapped, other rom ports pass straight through
	always_comb begin
		if (!rom2_n_i)
			rom_addr_o = {rom_bank, cpu_addr_i[17:1]};
		else
			rom_addr_o = cpu_addr_i;
	end

endmodule

// File: logic/viking_detect.sv
// viking detector that counts cpu accesses to the viking frame buffer to spot the driver
`timescale 1ns/1ps
`include "st_glue_params.svh"

module viking_detect (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  logic                    mhz8_en1_i,
	input  logic                    as_n_i,
	input  st_glue_pkg::word_addr_t cpu_addr_i,
	input  logic                    viking_enable_i,
	input  logic                    steroids_i,
	output logic                    viking_active_o
);

	localparam logic [5:0] LO_TAG = `ST_VIKING_LO_TAG;
	localparam logic [5:0] HI_TAG = `ST_VIKING_HI_TAG;

	logic [`ST_VIKING_COUNT_W-1:0] access_cnt;  // window hits so far
	logic [5:0]                    win_tag;     // active window tag
	logic                          win_hit;     // qualifying cpu access
	logic                          cnt_full;

	// card sits at $e80000 in steroids mode, $c00000 otherwise
	assign win_tag = steroids_i ? HI_TAG : LO_TAG;

	// one hit per 8 MHz bus clock with the address strobe down
	assign win_hit = mhz8_en1_i & ~as_n_i & viking_enable_i &
		(cpu_addr_i[23:18] == win_tag);

	assign cnt_full = &access_cnt;

	// software probing the range stays well below 256 hits,
	// the driver itself goes past it almost at once
	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint) begin
			access_cnt      <= '0;
			viking_active_o <= 1'b0;
		end else begin
			if (win_hit && !cnt_full)
				access_cnt <= access_cnt + {{(`ST_VIKING_COUNT_W-1){1'b0}}, 1'b1};  // saturates at 255

			// 256th hit finds the counter full
			if (win_hit && cnt_full)
				viking_active_o <= 1'b1;  // sticky until reset
		end
	end

endmodule

// File: ram_mux/ram_request_select.sv
// sdram request select: mmu window check and arbitration of upload, blitter, viking, mmu
`timescale 1ns/1ps
`include "st_glue_params.svh"

module ram_request_select (
	input  logic                    clk_32,
	input  logic                    xsint,
	input  st_glue_pkg::bus_cycle_e bus_cycle_i,
	input  st_glue_pkg::mem_size_e  mem_size_i,
	input  logic                    viking_enable_i,
	input  logic                    steroids_i,
	input  logic                    viking_active_i,
	input  st_glue_pkg::word_addr_t mcu_addr_i,
	input  logic                    mcu_ras_n_i,
	input  logic                    mcu_we_n_i,
	input  logic                    mcu_uds_i,
	input  logic                    mcu_lds_i,
	input  st_glue_pkg::bus_word_t  mcu_data_i,
	input  logic                    dio_download_i,
	input  logic                    upload_wr_i,
	input  st_glue_pkg::word_addr_t dio_addr_i,
	input  st_glue_pkg::bus_word_t  dio_data_i,
	input  logic                    blitter_bgack_i,
	input  logic                    blitter_read_i,
	input  logic                    blitter_write_i,
	input  st_glue_pkg::word_addr_t blitter_addr_i,
	input  st_glue_pkg::bus_word_t  blitter_data_i,
	input  logic                    viking_read_i,
	input  st_glue_pkg::word_addr_t viking_addr_i,
	output st_glue_pkg::word_addr_t sdram_addr_o,
	output st_glue_pkg::bus_word_t  sdram_data_o,
	output logic                    sdram_oe_o,
	output logic                    sdram_we_o,
	output logic                    sdram_uds_o,
	output logic                    sdram_lds_o
);
	import st_glue_pkg::*;

	localparam logic [5:0] VIKING_LO = `ST_VIKING_LO_TAG;
	localparam logic [5:0] VIKING_HI = `ST_VIKING_HI_TAG;

	logic     ras_n_q;     // ras level one clock back
	logic     cpu_cyc;
	logic     video_cyc;
	logic     ras_fall;    // first clock of an mmu access
	logic     mcu_oe;
	logic     mcu_we;
	logic     mem_en;      // inside configured st ram
	logic     viking_win;  // inside enabled viking frame buffer
	logic     ram_en;
	ram_src_e src;

	always_ff @(posedge clk_32 or negedge xsint) begin
		if (!xsint)
			ras_n_q <= 1'b1;  // idle ras is high
		else
			ras_n_q <= mcu_ras_n_i;
	end

	assign cpu_cyc   = (bus_cycle_i == CYC_CPU);
	assign video_cyc = (bus_cycle_i == CYC_VIDEO);

	assign ras_fall = ras_n_q & ~mcu_ras_n_i;
	assign mcu_oe   = ras_fall & mcu_we_n_i & (|mcu_addr_i);  // no reads of address 0
	assign mcu_we   = ras_fall & ~mcu_we_n_i;

	// upper ram limit per size code
	always_comb begin
		case (mem_size_i)
			MEM_512K: mem_en = (mcu_addr_i[23:19] == 5'b00000);
			MEM_1M:   mem_en = (mcu_addr_i[23:20] == 4'b0000);
			MEM_2M:   mem_en = (mcu_addr_i[23:21] == 3'b000);
			MEM_4M:   mem_en = (mcu_addr_i[23:22] == 2'b00);
			MEM_8M:   mem_en = ~mcu_addr_i[23];
			MEM_14M:  mem_en = ~(&mcu_addr_i[23:21]);  // stops below $e00000
			default:  mem_en = 1'b0;
		endcase
	end

	// low window is 256k at $c00000, high one 512k at $e80000
	always_comb begin
		if (!viking_enable_i)
			viking_win = 1'b0;
		else if (steroids_i)
			viking_win = (mcu_addr_i[23:19] == VIKING_HI[5:1]);
		else
			viking_win = (mcu_addr_i[23:18] == VIKING_LO);
	end

	assign ram_en = mem_en | viking_win;

	// fixed priority, upload over blitter over viking over mmu
	always_comb begin
		if (cpu_cyc && dio_download_i)
			src = SRC_UPLOAD;
		else if (cpu_cyc && blitter_bgack_i)
			src = SRC_BLITTER;
		else if (video_cyc && viking_active_i && viking_read_i)
			src = SRC_VIKING;
		else
			src = SRC_MCU;
	end

	always_comb begin
		case (src)
			SRC_UPLOAD: begin
				sdram_addr_o = dio_addr_i;
				sdram_oe_o   = 1'b0;         // upload only writes
				sdram_we_o   = upload_wr_i;
				sdram_uds_o  = 1'b1;
				sdram_lds_o  = 1'b1;
			end
			SRC_BLITTER: begin
				sdram_addr_o = blitter_addr_i;
				sdram_oe_o   = blitter_read_i;
				sdram_we_o   = blitter_write_i;
				sdram_uds_o  = 1'b1;         // blitter moves whole words
				sdram_lds_o  = 1'b1;
			end
			SRC_VIKING: begin
				sdram_addr_o = viking_addr_i;
				sdram_oe_o   = 1'b1;         // video fetch
				sdram_we_o   = 1'b0;
				sdram_uds_o  = mcu_uds_i;
				sdram_lds_o  = mcu_lds_i;
			end
			default: begin
				sdram_addr_o = mcu_addr_i;
				sdram_oe_o   = mcu_oe & ram_en;
				sdram_we_o   = mcu_we & ram_en;
				sdram_uds_o  = mcu_uds_i;
				sdram_lds_o  = mcu_lds_i;
			end
		endcase
	end

	// write data follows the bus owner, not the slot
	assign sdram_data_o = dio_download_i  ? dio_data_i     :
	                      blitter_bgack_i ? blitter_data_i : mcu_data_i;

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# build the st bus glue testbench with verilator, run it, pass only on the success line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f st_bus_glue.f --top-module st_bus_glue_tb -o st_bus_glue_sim \
	|| { echo "verilator build failed"; exit 1; }

sim_out=$(./obj_dir/st_bus_glue_sim 2>&1)
echo "$sim_out"

echo "$sim_out" | grep -qx "Simulation completed successfully" && exit 0 || exit 1

// File: st_bus_glue.f
+incdir+common
common/st_glue_pkg.sv
logic/sys_config_decode.sv
logic/viking_detect.sv
logic/tos_upload_ctrl.sv
ram_mux/ram_request_select.sv
logic/st_bus_glue.sv
bench/st_bus_glue_assertions.sv
bench/st_bus_glue_tb.sv
